// ==== vlog.f ====
+incdir+bench
rtl/rob_pkg.sv
rtl/rob_ptr_ctrl.sv
rtl/rob_entry_array.sv
rtl/rob_retire_sel.sv
rtl/rob_top.sv
bench/rob_tb.sv

// ==== bench/rob_ref.svh ====
`ifndef ROB_REF_SVH
`define ROB_REF_SVH

// ----------------------------------------------------------------------------
// Reference model, in-order queue of dispatched instructions
// ----------------------------------------------------------------------------

typedef struct packed {
    arch_reg_t arch_reg;
    tag_t      tag;
    tag_t      tag_old;
    logic      predict;
    logic      complete;
    logic      result;
} ref_ent_t;

// Oldest instruction at position 0
ref_ent_t ref_q[$];

// Buffer index of the oldest instruction
int ref_head;

// Size of this cycle's retire group
function automatic int exp_rt_num(input logic exc);
    int       n;
    logic     go;
    ref_ent_t e;
    n  = 0;
    go = !exc;
    for (int ch = 0; ch < RT_NUM; ch++) begin
        if (go && ch < ref_q.size()) begin
            e = ref_q[ch];
            if (e.complete) begin
                n++;
                // Group ends with a mispredicted branch
                if (e.predict != e.result) begin
                    go = 1'b0;
                end
            end else begin
                go = 1'b0;
            end
        end else begin
            go = 1'b0;
        end
    end
    return n;
endfunction

// Flush when the youngest retiring instruction is a wrong guess
function automatic logic exp_flush(input logic exc);
    int       n;
    ref_ent_t e;
    n = exp_rt_num(exc);
    if (n == 0) begin
        return 1'b0;
    end
    e = ref_q[n-1];
    return e.predict != e.result;
endfunction

// Free slots count the entries retiring this cycle
function automatic logic [DP_NUM-1:0] exp_ready_code(input logic exc);
    logic [DP_NUM-1:0] code;
    int                free;
    free = ROB_ENTRY_NUM - (ref_q.size() - exp_rt_num(exc));
    for (int i = 0; i < DP_NUM; i++) begin
        code[i] = (free > i);
    end
    return code;
endfunction

// Index handed to dispatch channel ch
function automatic rob_idx_t exp_idx(input int ch);
    return rob_idx_t'((ref_head + ref_q.size() + ch) % ROB_ENTRY_NUM);
endfunction

`endif

// ==== bench/rob_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_tb import rob_pkg::*; ();

    localparam int RUN_CYCLES  = 400;
    localparam int DRAIN_LIMIT = 200;

    logic                   clk_i;
    logic                   rst_i;
    logic                   exception_i;
    logic [DP_NUM-1:0]      dp_en_i;
    arch_reg_t [DP_NUM-1:0] dp_arch_reg_i;
    tag_t [DP_NUM-1:0]      dp_tag_i;
    tag_t [DP_NUM-1:0]      dp_tag_old_i;
    logic [DP_NUM-1:0]      dp_br_predict_i;
    logic [DP_NUM-1:0]      rob_ready_o;
    rob_idx_t [DP_NUM-1:0]  rob_idx_o;
    logic [CDB_NUM-1:0]     cdb_valid_i;
    rob_idx_t [CDB_NUM-1:0] cdb_rob_idx_i;
    logic [CDB_NUM-1:0]     cdb_br_result_i;
    logic [RT_NUM-1:0]      rt_valid_o;
    arch_reg_t [RT_NUM-1:0] rt_arch_reg_o;
    tag_t [RT_NUM-1:0]      rt_tag_o;
    tag_t [RT_NUM-1:0]      rt_tag_old_o;
    logic                   br_flush_o;

    int   seed;
    int   errors;
    int   checks;
    int   timer;
    logic check_en;

    `include "rob_ref.svh"

    rob_top u_rob_top (.*);

    always #10 clk_i = ~clk_i;

    // Compare one value, report a mismatch at once
    // Four-state compare so that X or Z on an output counts as a mismatch
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("Fail at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    // ------------------------------------------------------------------------
    // Random stimulus for one cycle
    // ------------------------------------------------------------------------

    task automatic drive_cycle(input logic allow_dp);
        logic [DP_NUM-1:0] ready;
        int                want;
        exception_i = allow_dp && (($random(seed) & 63) == 0);
        // Ready code already accounts for this cycle's exception
        ready = exp_ready_code(exception_i);
        want  = allow_dp ? ($random(seed) & 3) : 0;
        for (int ch = 0; ch < DP_NUM; ch++) begin
            dp_en_i[ch]         = (ch < want) && ready[ch];
            dp_arch_reg_i[ch]   = arch_reg_t'($random(seed));
            dp_tag_i[ch]        = tag_t'($random(seed));
            dp_tag_old_i[ch]    = tag_t'($random(seed));
            dp_br_predict_i[ch] = (($random(seed) & 7) == 0);
        end
        // Results at any index, empty or finished entries get ignored
        for (int c = 0; c < CDB_NUM; c++) begin
            cdb_valid_i[c]     = 1'($random(seed));
            cdb_rob_idx_i[c]   = rob_idx_t'($random(seed));
            cdb_br_result_i[c] = (($random(seed) & 15) == 0);
        end
        if (cdb_rob_idx_i[0] == cdb_rob_idx_i[1]) begin
            cdb_valid_i[1] = 1'b0;
        end
    endtask

    // ------------------------------------------------------------------------
    // Model update with the inputs of the cycle just checked
    // ------------------------------------------------------------------------

    task automatic step_model();
        int       n;
        int       pos;
        ref_ent_t e;
        n = exp_rt_num(exception_i);
        if (exception_i || exp_flush(exception_i)) begin
            // Whole buffer gone, dispatch and results dropped
            ref_q.delete();
            ref_head = 0;
        end else begin
            for (int c = 0; c < CDB_NUM; c++) begin
                pos = (int'(cdb_rob_idx_i[c]) - ref_head + ROB_ENTRY_NUM) % ROB_ENTRY_NUM;
                if (cdb_valid_i[c] && pos < ref_q.size()) begin
                    e = ref_q[pos];
                    if (!e.complete) begin
                        e.complete  = 1'b1;
                        e.result    = cdb_br_result_i[c];
                        ref_q[pos]  = e;
                    end
                end
            end
            for (int i = 0; i < n; i++) begin
                e = ref_q.pop_front();
            end
            ref_head = (ref_head + n) % ROB_ENTRY_NUM;
            for (int ch = 0; ch < DP_NUM; ch++) begin
                if (dp_en_i[ch]) begin
                    e.arch_reg = dp_arch_reg_i[ch];
                    e.tag      = dp_tag_i[ch];
                    e.tag_old  = dp_tag_old_i[ch];
                    e.predict  = dp_br_predict_i[ch];
                    e.complete = 1'b0;
                    e.result   = 1'b0;
                    ref_q.push_back(e);
                end
            end
        end
    endtask

    // Mid low phase, inputs settled and well before the rising edge
    always begin
        int       n;
        ref_ent_t e;
        @(negedge clk_i);
        #5;
        if (check_en) begin
            n = exp_rt_num(exception_i);
            check_value("rob_ready_o", rob_ready_o, exp_ready_code(exception_i));
            for (int ch = 0; ch < DP_NUM; ch++) begin
                check_value($sformatf("rob_idx_o[%0d]", ch), rob_idx_o[ch], exp_idx(ch));
            end
            for (int ch = 0; ch < RT_NUM; ch++) begin
                check_value($sformatf("rt_valid_o[%0d]", ch), rt_valid_o[ch], ch < n);
                if (ch < n) begin
                    e = ref_q[ch];
                    check_value($sformatf("rt_arch_reg_o[%0d]", ch), rt_arch_reg_o[ch],
                        e.arch_reg);
                    check_value($sformatf("rt_tag_o[%0d]", ch), rt_tag_o[ch], e.tag);
                    check_value($sformatf("rt_tag_old_o[%0d]", ch), rt_tag_old_o[ch],
                        e.tag_old);
                end
            end
            check_value("br_flush_o", br_flush_o, exp_flush(exception_i));
            step_model();
        end
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------

    initial begin
        seed            = 32'hf8b38811;
        errors          = 0;
        checks          = 0;
        check_en        = 1'b0;
        ref_head        = 0;
        clk_i           = 1'b0;
        rst_i           = 1'b1;
        exception_i     = 1'b0;
        dp_en_i         = '0;
        dp_arch_reg_i   = '0;
        dp_tag_i        = '0;
        dp_tag_old_i    = '0;
        dp_br_predict_i = '0;
        cdb_valid_i     = '0;
        cdb_rob_idx_i   = '0;
        cdb_br_result_i = '0;
        repeat (10) @(negedge clk_i);
        rst_i    = 1'b0;
        check_en = 1'b1;
        repeat (RUN_CYCLES) begin
            @(negedge clk_i);
            drive_cycle(1'b1);
        end
        // No new work, results only, until the buffer is empty
        timer = 0;
        while (ref_q.size() != 0 && timer < DRAIN_LIMIT) begin
            @(negedge clk_i);
            drive_cycle(1'b0);
            timer++;
        end
        if (ref_q.size() != 0) begin
            $display("Timeout: buffer did not drain within %0d cycles", DRAIN_LIMIT);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("Simulation FAILED");
            $finish;
        end else begin
            @(negedge clk_i);
            dp_en_i     = '0;
            cdb_valid_i = '0;
            exception_i = 1'b0;
            repeat (2) @(negedge clk_i);
            check_en = 1'b0;
            $display("Checks: %0d, errors: %0d", checks, errors);
            if (errors == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rob_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_top import rob_pkg::*; (
    input  logic                   clk_i,
    input  logic                   rst_i,
    input  logic                   exception_i,
    // Dispatch
    input  logic [DP_NUM-1:0]      dp_en_i,
    input  arch_reg_t [DP_NUM-1:0] dp_arch_reg_i,
    input  tag_t [DP_NUM-1:0]      dp_tag_i,
    input  tag_t [DP_NUM-1:0]      dp_tag_old_i,
    input  logic [DP_NUM-1:0]      dp_br_predict_i,
    output logic [DP_NUM-1:0]      rob_ready_o,
    output rob_idx_t [DP_NUM-1:0]  rob_idx_o,
    // Completion
    input  logic [CDB_NUM-1:0]     cdb_valid_i,
    input  rob_idx_t [CDB_NUM-1:0] cdb_rob_idx_i,
    input  logic [CDB_NUM-1:0]     cdb_br_result_i,
    // Retirement to map table and free list
    output logic [RT_NUM-1:0]      rt_valid_o,
    output arch_reg_t [RT_NUM-1:0] rt_arch_reg_o,
    output tag_t [RT_NUM-1:0]      rt_tag_o,
    output tag_t [RT_NUM-1:0]      rt_tag_old_o,
    output logic                   br_flush_o
);

    // Pointers
    rob_ptr_t                 head;
    rob_ptr_t                 tail;
    logic [ROB_ENTRY_NUM-1:0] dp_sel;

    // Retire control
    rob_cnt_t                 rt_num;
    logic [ROB_ENTRY_NUM-1:0] rt_clr;

    // Entry state
    logic [ROB_ENTRY_NUM-1:0]      ent_valid;
    logic [ROB_ENTRY_NUM-1:0]      ent_complete;
    logic [ROB_ENTRY_NUM-1:0]      ent_mispredict;
    arch_reg_t [ROB_ENTRY_NUM-1:0] ent_arch_reg;
    tag_t [ROB_ENTRY_NUM-1:0]      ent_tag;
    tag_t [ROB_ENTRY_NUM-1:0]      ent_tag_old;

    // Whole-buffer flush, exception or retiring mispredict
    logic flush;

    assign flush = exception_i | br_flush_o;

    rob_ptr_ctrl u_ptr_ctrl (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .dp_en_i     (dp_en_i),
        .rt_num_i    (rt_num),
        .flush_i     (flush),
        .head_o      (head),
        .tail_o      (tail),
        .dp_sel_o    (dp_sel),
        .rob_ready_o (rob_ready_o),
        .rob_idx_o   (rob_idx_o)
    );

    rob_entry_array u_entry_array (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .flush_i          (flush),
        .dp_sel_i         (dp_sel),
        .tail_i           (tail),
        .dp_arch_reg_i    (dp_arch_reg_i),
        .dp_tag_i         (dp_tag_i),
        .dp_tag_old_i     (dp_tag_old_i),
        .dp_br_predict_i  (dp_br_predict_i),
        .rt_clr_i         (rt_clr),
        .cdb_valid_i      (cdb_valid_i),
        .cdb_rob_idx_i    (cdb_rob_idx_i),
        .cdb_br_result_i  (cdb_br_result_i),
        .ent_valid_o      (ent_valid),
        .ent_complete_o   (ent_complete),
        .ent_mispredict_o (ent_mispredict),
        .ent_arch_reg_o   (ent_arch_reg),
        .ent_tag_o        (ent_tag),
        .ent_tag_old_o    (ent_tag_old)
    );

    rob_retire_sel u_retire_sel (
        .head_i           (head),
        .exception_i      (exception_i),
        .ent_valid_i      (ent_valid),
        .ent_complete_i   (ent_complete),
        .ent_mispredict_i (ent_mispredict),
        .ent_arch_reg_i   (ent_arch_reg),
        .ent_tag_i        (ent_tag),
        .ent_tag_old_i    (ent_tag_old),
        .rt_clr_o         (rt_clr),
        .rt_num_o         (rt_num),
        .rt_valid_o       (rt_valid_o),
        .rt_arch_reg_o    (rt_arch_reg_o),
        .rt_tag_o         (rt_tag_o),
        .rt_tag_old_o     (rt_tag_old_o),
        .br_flush_o       (br_flush_o)
    );

endmodule

`default_nettype wire

// ==== rtl/rob_retire_sel.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_retire_sel import rob_pkg::*; (
    input  rob_ptr_t                      head_i,
    input  logic                          exception_i,
    input  logic [ROB_ENTRY_NUM-1:0]      ent_valid_i,
    input  logic [ROB_ENTRY_NUM-1:0]      ent_complete_i,
    input  logic [ROB_ENTRY_NUM-1:0]      ent_mispredict_i,
    input  arch_reg_t [ROB_ENTRY_NUM-1:0] ent_arch_reg_i,
    input  tag_t [ROB_ENTRY_NUM-1:0]      ent_tag_i,
    input  tag_t [ROB_ENTRY_NUM-1:0]      ent_tag_old_i,
    output logic [ROB_ENTRY_NUM-1:0]      rt_clr_o,
    output rob_cnt_t                      rt_num_o,
    output logic [RT_NUM-1:0]             rt_valid_o,
    output arch_reg_t [RT_NUM-1:0]        rt_arch_reg_o,
    output tag_t [RT_NUM-1:0]             rt_tag_o,
    output tag_t [RT_NUM-1:0]             rt_tag_old_o,
    output logic                          br_flush_o
);

    // Entry covered by each retire channel
    rob_idx_t [RT_NUM-1:0] rt_ent;

    // ------------------------------------------------------------------------
    // Retire window
    // ------------------------------------------------------------------------

    // Channel ch looks at head + ch
    always_comb begin
        for (int ch = 0; ch < RT_NUM; ch++) begin
            rt_ent[ch] = rob_idx_t'(head_i[ROB_IDX_W-1:0] + ch);
        end
    end

    // Payload of the window, qualified by rt_valid_o downstream
    always_comb begin
        for (int ch = 0; ch < RT_NUM; ch++) begin
            rt_arch_reg_o[ch] = ent_arch_reg_i[rt_ent[ch]];
            rt_tag_o[ch]      = ent_tag_i[rt_ent[ch]];
            rt_tag_old_o[ch]  = ent_tag_old_i[rt_ent[ch]];
        end
    end

    // ------------------------------------------------------------------------
    // Retire group
    // ------------------------------------------------------------------------

    // Walk from the head in program order
    // Stops at the first incomplete entry
    // Stops after the first mispredicted branch, which itself retires
    always_comb begin
        logic go;
        go         = ~exception_i;
        rt_valid_o = '0;
        rt_clr_o   = '0;
        rt_num_o   = '0;
        br_flush_o = 1'b0;
        for (int ch = 0; ch < RT_NUM; ch++) begin
            if (go && ent_valid_i[rt_ent[ch]] && ent_complete_i[rt_ent[ch]]) begin
                rt_valid_o[ch]       = 1'b1;
                rt_clr_o[rt_ent[ch]] = 1'b1;
                rt_num_o             = rt_num_o + rob_cnt_t'(1);
                if (ent_mispredict_i[rt_ent[ch]]) begin
                    // Younger work is wrong path, flush it
                    br_flush_o = 1'b1;
                    go         = 1'b0;
                end
            end else begin
                go = 1'b0;
            end
        end
    end

    // Retire valids are a thermometer code from channel 0
    always_comb begin
        a_rt_thermo: assert final ($isunknown(rt_valid_o) ||
            ((rt_valid_o & (rt_valid_o + 1'b1)) == '0))
            else $error("retire valid is not a thermometer code");
    end

endmodule

`default_nettype wire

// ==== rtl/rob_entry_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_entry_array import rob_pkg::*; (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          flush_i,
    input  logic [ROB_ENTRY_NUM-1:0]      dp_sel_i,
    input  rob_ptr_t                      tail_i,
    input  arch_reg_t [DP_NUM-1:0]        dp_arch_reg_i,
    input  tag_t [DP_NUM-1:0]             dp_tag_i,
    input  tag_t [DP_NUM-1:0]             dp_tag_old_i,
    input  logic [DP_NUM-1:0]             dp_br_predict_i,
    input  logic [ROB_ENTRY_NUM-1:0]      rt_clr_i,
    input  logic [CDB_NUM-1:0]            cdb_valid_i,
    input  rob_idx_t [CDB_NUM-1:0]        cdb_rob_idx_i,
    input  logic [CDB_NUM-1:0]            cdb_br_result_i,
    output logic [ROB_ENTRY_NUM-1:0]      ent_valid_o,
    output logic [ROB_ENTRY_NUM-1:0]      ent_complete_o,
    output logic [ROB_ENTRY_NUM-1:0]      ent_mispredict_o,
    output arch_reg_t [ROB_ENTRY_NUM-1:0] ent_arch_reg_o,
    output tag_t [ROB_ENTRY_NUM-1:0]      ent_tag_o,
    output tag_t [ROB_ENTRY_NUM-1:0]      ent_tag_old_o
);

    // Per-entry state bits
    logic [ROB_ENTRY_NUM-1:0] valid_q;
    logic [ROB_ENTRY_NUM-1:0] complete_q;

    // Per-entry payload
    logic [ROB_ENTRY_NUM-1:0]      br_predict_q;
    logic [ROB_ENTRY_NUM-1:0]      br_result_q;
    arch_reg_t [ROB_ENTRY_NUM-1:0] arch_reg_q;
    tag_t [ROB_ENTRY_NUM-1:0]      tag_q;
    tag_t [ROB_ENTRY_NUM-1:0]      tag_old_q;

    // Dispatch data steered to each entry
    arch_reg_t [ROB_ENTRY_NUM-1:0] wr_arch_reg;
    tag_t [ROB_ENTRY_NUM-1:0]      wr_tag;
    tag_t [ROB_ENTRY_NUM-1:0]      wr_tag_old;
    logic [ROB_ENTRY_NUM-1:0]      wr_predict;

    // Result capture
    logic [ROB_ENTRY_NUM-1:0] cp_hit;
    logic [ROB_ENTRY_NUM-1:0] cp_result;
    logic [ROB_ENTRY_NUM-1:0] cp_take;

    // ------------------------------------------------------------------------
    // Dispatch steering
    // ------------------------------------------------------------------------

    // Channel ch lands on entry tail + ch
    always_comb begin
        wr_arch_reg = '0;
        wr_tag      = '0;
        wr_tag_old  = '0;
        wr_predict  = '0;
        for (int e = 0; e < ROB_ENTRY_NUM; e++) begin
            for (int ch = 0; ch < DP_NUM; ch++) begin
                if (rob_idx_t'(tail_i[ROB_IDX_W-1:0] + ch) == rob_idx_t'(e)) begin
                    wr_arch_reg[e] = dp_arch_reg_i[ch];
                    wr_tag[e]      = dp_tag_i[ch];
                    wr_tag_old[e]  = dp_tag_old_i[ch];
                    wr_predict[e]  = dp_br_predict_i[ch];
                end
            end
        end
    end

    // ------------------------------------------------------------------------
    // Result broadcast match
    // ------------------------------------------------------------------------

    // At most one channel per index in a cycle
    always_comb begin
        cp_hit    = '0;
        cp_result = '0;
        for (int e = 0; e < ROB_ENTRY_NUM; e++) begin
            for (int c = 0; c < CDB_NUM; c++) begin
                if (cdb_valid_i[c] && (cdb_rob_idx_i[c] == rob_idx_t'(e))) begin
                    cp_hit[e]    = 1'b1;
                    cp_result[e] = cdb_br_result_i[c];
                end
            end
        end
    end

    // Strobes to empty or already complete entries are dropped
    assign cp_take = cp_hit & valid_q & ~complete_q;

    // ------------------------------------------------------------------------
    // Entry update
    // ------------------------------------------------------------------------

    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ROB_ENTRY_NUM; e++) begin
            if (rst_i || flush_i) begin
                valid_q[e]    <= 1'b0;
                complete_q[e] <= 1'b0;
            end else if (dp_sel_i[e]) begin
                // New instruction, waits for its result
                valid_q[e]    <= 1'b1;
                complete_q[e] <= 1'b0;
            end else if (rt_clr_i[e]) begin
                valid_q[e]    <= 1'b0;
                complete_q[e] <= 1'b0;
            end else if (cp_take[e]) begin
                complete_q[e] <= 1'b1;
            end
        end
    end

    // Payload follows the same events
    always_ff @(posedge clk_i) begin
        for (int e = 0; e < ROB_ENTRY_NUM; e++) begin
            if (dp_sel_i[e]) begin
                arch_reg_q[e]   <= wr_arch_reg[e];
                tag_q[e]        <= wr_tag[e];
                tag_old_q[e]    <= wr_tag_old[e];
                br_predict_q[e] <= wr_predict[e];
            end
            // Resolved branch direction
            if (cp_take[e]) begin
                br_result_q[e] <= cp_result[e];
            end
        end
    end

    // Outputs
    assign ent_valid_o    = valid_q;
    assign ent_complete_o = complete_q;
    assign ent_arch_reg_o = arch_reg_q;
    assign ent_tag_o      = tag_q;
    assign ent_tag_old_o  = tag_old_q;

    // Result only meaningful once complete
    assign ent_mispredict_o = complete_q & (br_predict_q ^ br_result_q);

    // Retire selection only clears occupied, finished entries
    a_rt_clr: assert property (@(posedge clk_i) disable iff (rst_i)
        (rt_clr_i & ~(valid_q & complete_q)) == '0)
        else $error("retire clear on an entry that is not complete");

endmodule

`default_nettype wire

// ==== rtl/rob_ptr_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module rob_ptr_ctrl import rob_pkg::*; (
    input  logic                     clk_i,
    input  logic                     rst_i,
    input  logic [DP_NUM-1:0]        dp_en_i,
    input  rob_cnt_t                 rt_num_i,
    input  logic                     flush_i,
    output rob_ptr_t                 head_o,
    output rob_ptr_t                 tail_o,
    output logic [ROB_ENTRY_NUM-1:0] dp_sel_o,
    output logic [DP_NUM-1:0]        rob_ready_o,
    output rob_idx_t [DP_NUM-1:0]    rob_idx_o
);

    // Pointer registers
    rob_ptr_t head_q;
    rob_ptr_t tail_q;
    rob_ptr_t next_head;
    rob_ptr_t next_tail;

    // Counts
    rob_cnt_t dp_num;
    rob_cnt_t used_cnt;
    rob_cnt_t free_cnt;

    // Tail without the wrap bit
    rob_idx_t tail_idx;

    // ------------------------------------------------------------------------
    // Head and tail
    // ------------------------------------------------------------------------

    // Number of dispatching channels
    always_comb begin
        dp_num = '0;
        for (int i = 0; i < DP_NUM; i++) begin
            dp_num = dp_num + rob_cnt_t'(dp_en_i[i]);
        end
    end

    // Wrap bit rolls over together with the index
    assign next_head = head_q + rob_ptr_t'(rt_num_i);
    assign next_tail = tail_q + rob_ptr_t'(dp_num);

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            // Empty buffer restarts at entry 0
            head_q <= '0;
            tail_q <= '0;
        end else begin
            head_q <= next_head;
            tail_q <= next_tail;
        end
    end

    assign head_o   = head_q;
    assign tail_o   = tail_q;
    assign tail_idx = tail_q[ROB_IDX_W-1:0];

    // ------------------------------------------------------------------------
    // Free space and dispatch slots
    // ------------------------------------------------------------------------

    // Occupancy after this cycle's retirement
    // Modulo difference of the full pointers tells full from empty
    assign used_cnt = rob_cnt_t'(tail_q - next_head);
    assign free_cnt = rob_cnt_t'(ROB_ENTRY_NUM) - used_cnt;

    // Thermometer ready code and consecutive indices from the tail
    always_comb begin
        for (int i = 0; i < DP_NUM; i++) begin
            rob_ready_o[i] = (free_cnt > rob_cnt_t'(i));
            rob_idx_o[i]   = tail_idx + rob_idx_t'(i);
        end
    end

    // Dispatch enables rotated onto the entries starting at the tail
    always_comb begin
        dp_sel_o = '0;
        for (int i = 0; i < DP_NUM; i++) begin
            dp_sel_o[rob_idx_o[i]] = dp_en_i[i];
        end
    end

    // Dispatch channels fill from channel 0 upward
    a_dp_thermo: assert property (@(posedge clk_i) disable iff (rst_i)
        (dp_en_i & (dp_en_i + 1'b1)) == '0)
        else $error("dispatch enable is not a thermometer code");

    // Dispatcher never overruns the free slots
    a_dp_ready: assert property (@(posedge clk_i) disable iff (rst_i)
        (dp_en_i & ~rob_ready_o) == '0)
        else $error("dispatch on a channel that is not ready");

endmodule

`default_nettype wire

// ==== rtl/rob_pkg.sv ====
`default_nettype none

package rob_pkg;

    // ------------------------------------------------------------------------
    // Sizing
    // ------------------------------------------------------------------------

    // Instructions accepted per cycle
    localparam int DP_NUM        = 2;

    // Result broadcast channels
    localparam int CDB_NUM       = 2;

    // Instructions retired per cycle
    localparam int RT_NUM        = 2;

    // Buffer depth, kept a power of two so indices wrap naturally
    localparam int ROB_ENTRY_NUM = 8;
    localparam int ROB_IDX_W     = $clog2(ROB_ENTRY_NUM);

    // Register file sizes
    localparam int ARCH_REG_NUM  = 32;
    localparam int PHY_REG_NUM   = 64;

    // ------------------------------------------------------------------------
    // Types
    // ------------------------------------------------------------------------

    // Entry index
    typedef logic [ROB_IDX_W-1:0] rob_idx_t;

    // Entry index with wrap bit on top, for head and tail
    // Equal index with different wrap bit means full
    typedef logic [ROB_IDX_W:0] rob_ptr_t;

    // Count of entries, 0 up to ROB_ENTRY_NUM
    typedef logic [$clog2(ROB_ENTRY_NUM+1)-1:0] rob_cnt_t;

    // Architectural register number
    typedef logic [$clog2(ARCH_REG_NUM)-1:0] arch_reg_t;

    // Physical register tag
    typedef logic [$clog2(PHY_REG_NUM)-1:0] tag_t;

endpackage

`default_nettype wire
